//--- sim/tile_input_vectors.txt
# columns are mask op0 op1 a b c exp_valid exp_result, all in hex
# mask bit 2 is lane_a valid, bit 1 lane_b, bit 0 lane_c
# opcodes 0 add, 1 sub, 2 unsigned mul, 3 signed mul
7 0 0 00000000FFFFFFFF 0000000000000001 0000000000000000 1 0000000100000000
7 0 0 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000005 1 0000000000000005
7 1 0 0000000000000000 0000000000000001 0000000000000000 1 FFFFFFFFFFFFFFFF
7 2 0 DEADBEEF00000003 CAFEBABE00000005 0000000000000000 1 000000000000000F
7 3 0 00000000FFFFFFFF 0000000000000002 0000000000000000 1 FFFFFFFFFFFFFFFE
7 0 0 123456789ABCDEF0 0FEDCBA987654321 1111111111111111 1 3333333333333322
7 1 1 0000000100000000 0000000000000001 00000000FFFFFFFF 1 0000000000000000
7 2 0 11111111FFFFFFFF 22222222FFFFFFFF 0000000000000001 1 FFFFFFFE00000002
7 3 0 0000000080000000 0000000080000000 0000000000000000 1 4000000000000000
3 0 0 0000000000000001 0000000000000002 0000000000000003 0 0000000000000000
7 0 2 0000000000000002 0000000000000003 AAAAAAAA00000007 1 0000000000000023
7 0 3 00000000FFFFFFFE 0000000000000000 0000000000000005 1 FFFFFFFFFFFFFFF6
7 0 1 8000000000000000 8000000000000000 0000000000000001 1 FFFFFFFFFFFFFFFF
7 2 0 0000000100010000 FFFFFFFF00010000 0000000000000000 1 0000000100000000
7 3 0 00000000FFFFFFFF 00000000FFFFFFFF 0000000000000000 1 0000000000000001
5 2 0 0000000000000004 0000000000000005 0000000000000006 0 0000000000000000
7 1 3 0000000000000005 0000000000000008 0000000000000003 1 FFFFFFFFFFFFFFF7
7 1 2 0000000000000005 0000000000000008 0000000000000003 1 00000002FFFFFFF7
7 3 1 0000000000000007 00000000FFFFFFFA 0000000000000001 1 FFFFFFFFFFFFFFD5
7 1 0 0000000000000010 0000000000000020 0000000000000010 1 0000000000000000
7 2 2 FFFFFFFF00000010 0000000100000010 0000000000001000 1 0000000000100000
7 3 0 123456787FFFFFFF 0000000080000000 0000000000000000 1 C000000080000000
6 1 3 00000000000000AA 0000000000000055 0000000000000011 0 0000000000000000
7 2 1 0000000000000100 0000000000000100 0000000000000001 1 000000000000FFFF
7 0 3 000000007FFFFFFF 0000000000000001 0000000000000002 1 FFFFFFFF00000000
7 3 3 0000000000000002 00000000FFFFFFFF 00000000FFFFFFFF 1 0000000000000002
7 2 3 0000000000010000 0000000000008000 0000000000000003 1 FFFFFFFE80000000
7 0 1 00000000FFFFFFFF 00000000FFFFFFFF 0000000000000001 1 00000001FFFFFFFD
7 3 0 FFFFFFFF00000003 00000000FFFFFFFD 0000000000000009 1 0000000000000000
0 3 1 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0 0000000000000000
7 2 0 00000000FFFFFFFF 0000000000000002 0000000000000000 1 00000001FFFFFFFE
7 3 0 0000000080000000 00000000FFFFFFFF 0000000000000000 1 0000000080000000
7 1 0 0000000100000000 0000000000000001 0000000000000001 1 0000000100000000
7 0 0 7FFFFFFFFFFFFFFF 0000000000000001 7FFFFFFFFFFFFFFF 1 FFFFFFFFFFFFFFFF
7 1 1 0000000000000000 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 1 0000000000000002

//--- sim.f
+incdir+logic
logic/pe_data_pkg.sv
logic/pe_ctrl_pkg.sv
logic/register_pipe.sv
logic/int_addsub_pipe.sv
logic/int_mult_pipe.sv
logic/pe_type_a.sv
logic/pe_pair_tile.sv
sim/tb_pe_pair_tile.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

# vector file path is relative to the project root
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_pe_pair_tile \
  -f sim.f \
  --Mdir obj_dir \
  -o tb_pe_pair_tile

./obj_dir/tb_pe_pair_tile

//--- sim/tb_pe_pair_tile.sv
`default_nettype none

`include "pe_cfg.svh"

// drives the two-pe tile from a vector file and checks every output cycle
module tb_pe_pair_tile;

  localparam int unsigned TILE_LATENCY = 2 * `PE_LATENCY; // edge in to result out
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned START_LIMIT  = 64;    // cycles allowed before first item
  localparam int unsigned CHECK_LIMIT  = 1000;  // upper bound on checker cycles
  localparam int unsigned DRAIN_LIMIT  = TILE_LATENCY + 8;
  localparam string       VEC_FILE     = "sim/tile_input_vectors.txt";

  // one expected output cycle
  typedef struct packed {
    logic [31:0]        row;    // file row, 0 for an idle gap
    logic               valid;
    pe_data_pkg::word_t data;   // only meaningful when valid
  } expect_t;

  logic                   clk;
  logic                   arst_n;
  pe_ctrl_pkg::pe_lane_t  lane_a;
  pe_ctrl_pkg::pe_lane_t  lane_b;
  pe_ctrl_pkg::pe_lane_t  lane_c;
  pe_ctrl_pkg::tile_cmd_t cmd;
  pe_ctrl_pkg::pe_lane_t  result;

  expect_t     exp_q [$];              // one entry per driven cycle
  logic        drive_started = 1'b0;   // set at the first item edge
  logic [31:0] lcg_state = 32'd98355;  // gap generator state

  pe_pair_tile UUT (
    .clk    (clk),
    .arst_n (arst_n),
    .lane_a (lane_a),
    .lane_b (lane_b),
    .lane_c (lane_c),
    .cmd    (cmd),
    .result (result)
  );

  // period 4
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t: %s result.valid got %b expected %b",
                                  $time, what, got, exp));
    end
  endtask

  task automatic check_data(input pe_data_pkg::word_t got, input pe_data_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t: %s result.data got %h expected %h",
                                  $time, what, got, exp));
    end
  endtask

  task automatic clear_valids();
    lane_a.valid <= 1'b0; // data and cmd left as they were
    lane_b.valid <= 1'b0;
    lane_c.valid <= 1'b0;
  endtask

  // one row on the next rising edge, plus its expectation
  task automatic drive_item(input logic [31:0] row, input logic [2:0] mask,
                            input logic [1:0] op0, input logic [1:0] op1,
                            input pe_data_pkg::word_t a, input pe_data_pkg::word_t b,
                            input pe_data_pkg::word_t c, input logic exp_valid,
                            input pe_data_pkg::word_t exp_data);
    expect_t e;
    @(posedge clk);
    lane_a.data  <= a;
    lane_a.valid <= mask[2];
    lane_b.data  <= b;
    lane_b.valid <= mask[1];
    lane_c.data  <= c;
    lane_c.valid <= mask[0];
    cmd.op0      <= pe_data_pkg::pe_op_e'(op0);
    cmd.op1      <= pe_data_pkg::pe_op_e'(op1);
    e.row   = row;
    e.valid = exp_valid;
    e.data  = exp_data;
    exp_q.push_back(e);
    drive_started = 1'b1; // checker lines up on this edge
  endtask

  // bubble cycle, result must come out invalid
  task automatic drive_idle();
    expect_t e;
    @(posedge clk);
    clear_valids();
    e.row   = '0;
    e.valid = 1'b0;
    e.data  = '0;
    exp_q.push_back(e);
  endtask

  task automatic run_vectors(input int fd, output int unsigned rows_read);
    string              line;
    int                 code;
    int                 fields;
    int unsigned        gap;
    logic [2:0]         mask;
    logic [1:0]         op0_raw;
    logic [1:0]         op1_raw;
    pe_data_pkg::word_t a_val;
    pe_data_pkg::word_t b_val;
    pe_data_pkg::word_t c_val;
    logic               exp_valid;
    pe_data_pkg::word_t exp_data;
    rows_read = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      // skip comments and blank lines
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h", mask, op0_raw, op1_raw,
                         a_val, b_val, c_val, exp_valid, exp_data);
        if (fields != 8) begin
          stop_with_failure($sformatf("malformed vector row: %s", line));
        end else begin
          rows_read++;
          if (rows_read > 1) begin
            gap = (lcg_next() >> 16) & 32'd3; // 0..3 idle cycles
            for (int i = 0; i < gap; i++) begin
              drive_idle();
            end
          end
          drive_item(rows_read, mask, op0_raw, op1_raw, a_val, b_val, c_val,
                     exp_valid, exp_data);
        end
      end
    end
    drive_idle(); // nothing more enters the tile
  endtask

  task automatic wait_for_drain();
    int unsigned n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      stop_with_failure($sformatf("results did not drain within %0d cycles", DRAIN_LIMIT));
    end else begin
      $display("TB PASSED");
      $finish;
    end
  endtask

  initial begin : stimulus
    int          fd;
    int unsigned rows;
    arst_n <= 1'b0; // reset from time 0
    lane_a <= '0;
    lane_b <= '0;
    lane_c <= '0;
    cmd    <= '0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
    end
    arst_n <= 1'b1;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      stop_with_failure($sformatf("could not open vector file %s", VEC_FILE));
    end else begin
      run_vectors(fd, rows);
      $fclose(fd);
      if (rows == 0) begin
        stop_with_failure("vector file held no rows");
      end else begin
        wait_for_drain();
      end
    end
  end

  // samples on the falling edge, half a cycle clear of the drive
  initial begin : result_checker
    int unsigned waited;
    expect_t     e;
    string       what;
    waited = 0;
    // reset and idle lead-in, nothing valid may leave the tile
    while (!drive_started && waited < START_LIMIT) begin
      @(negedge clk);
      check_valid(result.valid, 1'b0, "before first item");
      waited++;
    end
    if (!drive_started) begin
      stop_with_failure($sformatf("no vector was driven within %0d cycles", START_LIMIT));
    end else begin
      // first item still inside the two pes
      for (int i = 0; i < TILE_LATENCY - 1; i++) begin
        @(negedge clk);
        check_valid(result.valid, 1'b0, "first item in flight");
      end
      for (int n = 0; n < CHECK_LIMIT; n++) begin
        @(negedge clk);
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          what = (e.row == 0) ? "idle cycle" : $sformatf("row %0d", e.row);
          check_valid(result.valid, e.valid, what);
          if (e.valid) begin
            check_data(result.data, e.data, what);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/pe_pair_tile.sv
`default_nettype none

`include "pe_cfg.svh"

// two-pe chain, result = (a op0 b) op1 c
// 12 clocks input to result, one item per clock
module pe_pair_tile (
  input  logic                   clk,
  input  logic                   arst_n,
  input  pe_ctrl_pkg::pe_lane_t  lane_a,
  input  pe_ctrl_pkg::pe_lane_t  lane_b,
  input  pe_ctrl_pkg::pe_lane_t  lane_c,
  input  pe_ctrl_pkg::tile_cmd_t cmd,
  output pe_ctrl_pkg::pe_lane_t  result
);

  localparam int unsigned LANEW = $bits(pe_ctrl_pkg::pe_lane_t);
  localparam int unsigned OPW   = $bits(pe_data_pkg::pe_op_e);

  pe_ctrl_pkg::pe_lane_t mid;       // pe0 result, PE_LATENCY late
  pe_ctrl_pkg::pe_lane_t lane_c_d;  // c lined up with mid
  logic [OPW-1:0]        op1_bits;  // op1 lined up with mid
  pe_data_pkg::pe_op_e   op1_d;

  // first stage, a op0 b
  pe_type_a pe0 (
    .clk    (clk),
    .arst_n (arst_n),
    .inp1   (lane_a),
    .inp2   (lane_b),
    .op     (cmd.op0),
    .out1   (mid)
  );

  // c waits while pe0 works
  register_pipe #(
    .width      (LANEW),
    .num_stages (`PE_LATENCY)
  ) c_align (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (lane_c),
    .dout   (lane_c_d)
  );

  // second opcode waits too
  register_pipe #(
    .width      (OPW),
    .num_stages (`PE_LATENCY)
  ) op1_align (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (cmd.op1),
    .dout   (op1_bits)
  );

  assign op1_d = pe_data_pkg::pe_op_e'(op1_bits);

  // second stage, mid op1 c
  // valid here needs a, b and c all valid
  pe_type_a pe1 (
    .clk    (clk),
    .arst_n (arst_n),
    .inp1   (mid),
    .inp2   (lane_c_d),
    .op     (op1_d),
    .out1   (result)
  );

endmodule

`default_nettype wire

//--- logic/pe_type_a.sv
`default_nettype none

`include "pe_cfg.svh"

// integer pe
// both datapaths run on every item
// delayed opcode picks which one reaches out1
module pe_type_a (
  input  logic                  clk,
  input  logic                  arst_n,
  input  pe_ctrl_pkg::pe_lane_t inp1,
  input  pe_ctrl_pkg::pe_lane_t inp2,
  input  pe_data_pkg::pe_op_e   op,
  output pe_ctrl_pkg::pe_lane_t out1
);

  localparam int unsigned OPW = $bits(pe_data_pkg::pe_op_e);

  pe_data_pkg::word_t  t_add;      // sum path, PE_LATENCY late
  pe_data_pkg::word_t  t_mul;      // product path, same latency
  logic                vld_in;     // both operands present
  logic                vld_q;
  logic [OPW-1:0]      op_bits_q;  // raw delayed opcode
  pe_data_pkg::pe_op_e op_q;

  assign vld_in = inp1.valid & inp2.valid;

  int_addsub_pipe addsub_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .a      (inp1.data),
    .b      (inp2.data),
    .sub    (op == pe_data_pkg::OP_SUB), // don't care for mult ops
    .sum    (t_add)
  );

  int_mult_pipe mult_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .a         (inp1.data[`DWIDTH_INT-1:0]), // high halves ignored
    .b         (inp2.data[`DWIDTH_INT-1:0]),
    .is_signed (op == pe_data_pkg::OP_MULS),
    .prod      (t_mul)
  );

  register_pipe #(
    .width      (1),
    .num_stages (`PE_LATENCY)
  ) vld_pipe (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (vld_in),
    .dout   (vld_q)
  );

  // opcode rides beside its item
  register_pipe #(
    .width      (OPW),
    .num_stages (`PE_LATENCY)
  ) op_pipe (
    .clk    (clk),
    .arst_n (arst_n),
    .din    (op),
    .dout   (op_bits_q)
  );

  assign op_q = pe_data_pkg::pe_op_e'(op_bits_q);

  // output mux, purely comb
  always_comb begin
    out1.valid = vld_q;
    case (op_q)
      pe_data_pkg::OP_ADD,
      pe_data_pkg::OP_SUB:  out1.data = t_add;
      pe_data_pkg::OP_MULU,
      pe_data_pkg::OP_MULS: out1.data = t_mul;
      default:              out1.data = t_add;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/int_mult_pipe.sv
`default_nettype none

`include "pe_cfg.svh"

// 32x32 -> 64 multiplier, signed or unsigned per item
// total latency PE_LATENCY
module int_mult_pipe (
  input  logic               clk,
  input  logic               arst_n,
  input  pe_data_pkg::half_t a,
  input  pe_data_pkg::half_t b,
  input  logic               is_signed, // 1 = two's complement operands
  output pe_data_pkg::word_t prod
);

  localparam int unsigned NSTG = `PE_LATENCY;
  localparam int unsigned XW   = `DWIDTH_INT + 1;  // extended operand
  localparam int unsigned PW   = 2 * XW;           // full signed product

  pe_data_pkg::half_t a_q;          // stage 1 operands
  pe_data_pkg::half_t b_q;
  logic               sgn_q;        // stage 1 mode

  logic signed [XW-1:0] a_ext;
  logic signed [XW-1:0] b_ext;
  logic signed [PW-1:0] prod_full;

  pe_data_pkg::word_t prod_q [NSTG-1]; // stages 2..NSTG

  // extra top bit is a copy of the msb only in signed mode
  // unsigned operands get a zero there and stay positive
  assign a_ext = {sgn_q & a_q[`DWIDTH_INT-1], a_q};
  assign b_ext = {sgn_q & b_q[`DWIDTH_INT-1], b_q};

  assign prod_full = a_ext * b_ext; // one signed mult covers both modes

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_q   <= '0;
      b_q   <= '0;
      sgn_q <= 1'b0;
      for (int i = 0; i < NSTG - 1; i++) begin
        prod_q[i] <= '0;
      end
    end else begin
      a_q   <= a;
      b_q   <= b;
      sgn_q <= is_signed;
      prod_q[0] <= prod_full[`DWIDTH_DOUBLE-1:0]; // low 64 bits carry the answer
      for (int i = 1; i < NSTG - 1; i++) begin
        prod_q[i] <= prod_q[i-1]; // retime to total latency
      end
    end
  end

  assign prod = prod_q[NSTG-2];

endmodule

`default_nettype wire

//--- logic/int_addsub_pipe.sv
`default_nettype none

`include "pe_cfg.svh"

// 64-bit add/sub, result comes out PE_LATENCY clocks later
module int_addsub_pipe (
  input  logic               clk,
  input  logic               arst_n,
  input  pe_data_pkg::word_t a,
  input  pe_data_pkg::word_t b,
  input  logic               sub,  // 1 = a - b
  output pe_data_pkg::word_t sum
);

  localparam int unsigned NSTG = `PE_LATENCY;

  pe_data_pkg::word_t sum_d;            // comb result of this item
  pe_data_pkg::word_t sum_q [NSTG];     // [0] holds the fresh result

  // sub sampled in the same cycle as a and b
  // so every item keeps its own operation
  always_comb begin
    if (sub) begin
      sum_d = a - b; // wraps mod 2^64
    end else begin
      sum_d = a + b; // carry out dropped
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NSTG; i++) begin
        sum_q[i] <= '0;
      end
    end else begin
      sum_q[0] <= sum_d; // stage 1, the real work
      // remaining stages only retime
      for (int i = 1; i < NSTG; i++) begin
        sum_q[i] <= sum_q[i-1];
      end
    end
  end

  assign sum = sum_q[NSTG-1];

endmodule

`default_nettype wire

//--- logic/register_pipe.sv
`default_nettype none

// plain delay line, num_stages flops deep
module register_pipe #(
  parameter int unsigned width      = 1,
  parameter int unsigned num_stages = 1
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [width-1:0] din,
  output logic [width-1:0] dout
);

  generate
    if (num_stages == 0) begin : g_bypass
      assign dout = din; // no delay asked for
    end else begin : g_stages
      logic [width-1:0] stage_q [num_stages]; // [0] is nearest din

      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          for (int i = 0; i < num_stages; i++) begin
            stage_q[i] <= '0; // pipe empty after reset
          end
        end else begin
          stage_q[0] <= din;
          for (int i = 1; i < num_stages; i++) begin
            stage_q[i] <= stage_q[i-1]; // shift one step per clk
          end
        end
      end

      assign dout = stage_q[num_stages-1];
    end
  endgenerate

endmodule

`default_nettype wire

//--- logic/pe_ctrl_pkg.sv
`default_nettype none

// streaming side of the tile: lanes and commands
package pe_ctrl_pkg;

  // one streamed word with its strobe
  // 65 bits, data in the upper bits
  typedef struct packed {
    pe_data_pkg::word_t data;
    logic               valid; // qualifies data, no handshake
  } pe_lane_t;

  // both operations of one item
  // op0 used by pe0 right away
  // op1 delayed to meet the first result
  typedef struct packed {
    pe_data_pkg::pe_op_e op0;
    pe_data_pkg::pe_op_e op1;
  } tile_cmd_t;

endpackage

`default_nettype wire

//--- logic/pe_data_pkg.sv
`default_nettype none

`include "pe_cfg.svh"

// data side of the tile: words and operations
package pe_data_pkg;

  // one operand or result
  typedef logic [`DWIDTH_DOUBLE-1:0] word_t;

  // low half, what the multiplier sees
  typedef logic [`DWIDTH_INT-1:0] half_t;

  // per-item opcode, travels with its data
  typedef enum logic [1:0] {
    OP_ADD  = 2'b00, // wrapping 64-bit sum
    OP_SUB  = 2'b01, // inp1 - inp2, wrapping
    OP_MULU = 2'b10, // unsigned low-half product
    OP_MULS = 2'b11  // signed low-half product
  } pe_op_e;

endpackage

`default_nettype wire

//--- logic/pe_cfg.svh
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// widths and latency shared by the integer tile

// narrow operand, the multiplier input
`define DWIDTH_INT 32

// full word, the adder and the product width
`define DWIDTH_DOUBLE 64

// cycles from pe input edge to pe output
// adder and multiplier pipes are both tuned to this
`define PE_LATENCY 6

`endif
